/* hw/keyer_pkg.sv */
package keyer_pkg;

  // ==============================
  // pixel and coordinate types
  // ==============================

  // frame-buffer word, red 15:11, green 10:5, blue 4:0
  typedef logic [15:0] pixel565_t;

  // one color or chroma channel
  typedef logic [7:0] chan_t;

  // expanded camera pixel, red in the top byte
  typedef struct packed {
    chan_t red;
    chan_t green;
    chan_t blue;
  } rgb_t;

  typedef logic [10:0] hcount_t;
  typedef logic [9:0]  vcount_t;

  // switch nibble, the bound it sets is this value times 16
  typedef logic [3:0] bound_t;

  // output view select
  typedef enum logic [1:0] {
    MODE_CAMERA    = 2'd0,
    MODE_LUMA      = 2'd1,
    MODE_MASK      = 2'd2,
    MODE_CROSSHAIR = 2'd3
  } disp_mode_t;

  // ==============================
  // pipeline constants
  // ==============================

  // coordinate out, pixel back from the frame buffer
  localparam int FETCH_LATENCY = 1;
  // pixel in to registered key mask
  localparam int KEY_LATENCY = 4;
  // coordinate to video outputs, plus one for the mux register
  localparam int OUT_LATENCY = FETCH_LATENCY + KEY_LATENCY + 1;

  // full red for the centroid crosshair
  localparam rgb_t CROSSHAIR_COLOR = '{red: 8'hFF, green: 8'h00, blue: 8'h00};

endpackage

/* hw/delay_line.sv */
module delay_line #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 1
) (
  input  logic     clk_pixel,
  input  logic     recent_reset,
  input  payload_t data_i,
  output payload_t data_o
);

  // stage 0 takes the input, the last one drives the output
  payload_t stage_q [DEPTH];

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= data_i;
      for (int i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign data_o = stage_q[DEPTH-1];

endmodule

/* hw/video_timing.sv */
module video_timing #(
  parameter int H_ACTIVE = 1280,
  parameter int H_FRONT  = 110,
  parameter int H_SYNC   = 40,
  parameter int H_BACK   = 220,
  parameter int V_ACTIVE = 720,
  parameter int V_FRONT  = 5,
  parameter int V_SYNC   = 5,
  parameter int V_BACK   = 20
) (
  input  logic               clk_pixel,
  input  logic               recent_reset,
  output keyer_pkg::hcount_t hcount_o,
  output keyer_pkg::vcount_t vcount_o,
  output logic               hsync_o,
  output logic               vsync_o,
  output logic               active_o,
  output logic               new_frame_o
);

  // ==============================
  // interval edges
  // ==============================

  // along a line
  localparam keyer_pkg::hcount_t H_END_ACT = keyer_pkg::hcount_t'(H_ACTIVE);
  localparam keyer_pkg::hcount_t H_SYNC_ON = keyer_pkg::hcount_t'(H_ACTIVE + H_FRONT);
  localparam keyer_pkg::hcount_t H_SYNC_OFF =
    keyer_pkg::hcount_t'(H_ACTIVE + H_FRONT + H_SYNC);
  localparam keyer_pkg::hcount_t H_LAST =
    keyer_pkg::hcount_t'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);

  // down the frame
  localparam keyer_pkg::vcount_t V_END_ACT = keyer_pkg::vcount_t'(V_ACTIVE);
  localparam keyer_pkg::vcount_t V_LAST_ACT = keyer_pkg::vcount_t'(V_ACTIVE - 1);
  localparam keyer_pkg::vcount_t V_SYNC_ON = keyer_pkg::vcount_t'(V_ACTIVE + V_FRONT);
  localparam keyer_pkg::vcount_t V_SYNC_OFF =
    keyer_pkg::vcount_t'(V_ACTIVE + V_FRONT + V_SYNC);
  localparam keyer_pkg::vcount_t V_LAST =
    keyer_pkg::vcount_t'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);

  // raster scan, one position per cycle, never stalls
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      hcount_o <= '0;
      vcount_o <= '0;
    end else if (hcount_o == H_LAST) begin
      hcount_o <= '0;
      // end of line, step or wrap the row
      if (vcount_o == V_LAST) begin
        vcount_o <= '0;
      end else begin
        vcount_o <= vcount_o + 1'b1;
      end
    end else begin
      hcount_o <= hcount_o + 1'b1;
    end
  end

  // decodes for the current coordinate
  assign hsync_o  = (hcount_o >= H_SYNC_ON) && (hcount_o < H_SYNC_OFF);
  assign vsync_o  = (vcount_o >= V_SYNC_ON) && (vcount_o < V_SYNC_OFF);
  assign active_o = (hcount_o < H_END_ACT) && (vcount_o < V_END_ACT);

  // one cycle right after the last active pixel of the frame
  assign new_frame_o = (hcount_o == H_END_ACT) && (vcount_o == V_LAST_ACT);

endmodule

/* hw/chroma_key.sv */
module chroma_key (
  input  logic                 clk_pixel,
  input  logic                 recent_reset,
  input  keyer_pkg::pixel565_t pixel_i,
  input  keyer_pkg::bound_t    cr_upper_i,
  input  keyer_pkg::bound_t    cb_upper_i,
  output keyer_pkg::rgb_t      rgb_o,
  output keyer_pkg::chan_t     luma_o,
  output logic                 key_o
);

  // ==============================
  // stage 1, expand to 8 bits
  // ==============================

  keyer_pkg::rgb_t rgb_s1;

  // low bits zero filled
  always_ff @(posedge clk_pixel) begin
    rgb_s1.red   <= {pixel_i[15:11], 3'b000};
    rgb_s1.green <= {pixel_i[10:5], 2'b00};
    rgb_s1.blue  <= {pixel_i[4:0], 3'b000};
  end

  // ==============================
  // stage 2, constant products
  // ==============================

  // negative coefficients are kept as magnitudes here
  logic [15:0] y_r, y_g, y_b;
  logic [15:0] cr_r, cr_g, cr_b;
  logic [15:0] cb_r, cb_g, cb_b;

  always_ff @(posedge clk_pixel) begin
    y_r  <= 16'(rgb_s1.red) * 16'd66;
    y_g  <= 16'(rgb_s1.green) * 16'd129;
    y_b  <= 16'(rgb_s1.blue) * 16'd25;
    cr_r <= 16'(rgb_s1.red) * 16'd112;
    cr_g <= 16'(rgb_s1.green) * 16'd94;
    cr_b <= 16'(rgb_s1.blue) * 16'd18;
    cb_r <= 16'(rgb_s1.red) * 16'd38;
    cb_g <= 16'(rgb_s1.green) * 16'd74;
    cb_b <= 16'(rgb_s1.blue) * 16'd112;
  end

  // ==============================
  // stage 3, sums
  // ==============================

  // y sum peaks at 220*255, fits 16 bits unsigned
  logic [15:0]        y_sum;
  // chroma sums stay within +/-28560
  logic signed [16:0] cr_sum;
  logic signed [16:0] cb_sum;

  always_ff @(posedge clk_pixel) begin
    y_sum  <= y_r + y_g + y_b;
    cr_sum <= $signed({1'b0, cr_r}) - $signed({1'b0, cr_g}) - $signed({1'b0, cr_b});
    cb_sum <= $signed({1'b0, cb_b}) - $signed({1'b0, cb_r}) - $signed({1'b0, cb_g});
  end

  // bits 15:8 are the sum shifted right by 8, cut to one channel
  keyer_pkg::chan_t luma_s3;
  keyer_pkg::chan_t cr_s3;
  keyer_pkg::chan_t cb_s3;

  assign luma_s3 = y_sum[15:8] + 8'd16;
  assign cr_s3   = cr_sum[15:8] + 8'd128;
  assign cb_s3   = cb_sum[15:8] + 8'd128;

  // ==============================
  // stage 4, threshold
  // ==============================

  // lower bounds are zero, so only the upper compare remains
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      key_o <= 1'b0;
    end else begin
      key_o <= (cr_s3 <= {cr_upper_i, 4'b0000}) && (cb_s3 <= {cb_upper_i, 4'b0000});
    end
  end

  // pixel leaves stage 1, three more cycles to meet the mask
  delay_line #(
    .payload_t(keyer_pkg::rgb_t),
    .DEPTH(keyer_pkg::KEY_LATENCY - 1)
  ) rgb_delay (
    .clk_pixel(clk_pixel),
    .recent_reset(recent_reset),
    .data_i(rgb_s1),
    .data_o(rgb_o)
  );

  // luma is ready with the sums, one cycle short of the mask
  delay_line #(
    .payload_t(keyer_pkg::chan_t),
    .DEPTH(keyer_pkg::KEY_LATENCY - 3)
  ) luma_delay (
    .clk_pixel(clk_pixel),
    .recent_reset(recent_reset),
    .data_i(luma_s3),
    .data_o(luma_o)
  );

endmodule

/* hw/seq_divider.sv */
module seq_divider (
  input  logic        clk_pixel,
  input  logic        recent_reset,
  input  logic        start_i,
  input  logic [31:0] dividend_i,
  input  logic [20:0] divisor_i,
  output logic [31:0] quotient_o,
  output logic        done_o
);

  logic        busy_q;
  logic [4:0]  bit_cnt_q;
  logic        load;

  // dividend shifts out the top as quotient bits shift in below
  logic [31:0] quo_q;
  logic [20:0] rem_q;
  logic [20:0] div_q;

  // partial remainder with the next dividend bit brought down
  logic [21:0] rem_shift;
  logic [21:0] rem_sub;
  logic        fits;

  // a start while busy is dropped
  assign load      = start_i && !busy_q;
  assign rem_shift = {rem_q, quo_q[31]};
  assign rem_sub   = rem_shift - {1'b0, div_q};
  assign fits      = rem_shift >= {1'b0, div_q};

  // iteration count and done strobe
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      busy_q    <= 1'b0;
      bit_cnt_q <= '0;
      done_o    <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (load) begin
        busy_q    <= 1'b1;
        bit_cnt_q <= '0;
      end else if (busy_q) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
        // 32nd bit lands on this edge
        if (bit_cnt_q == 5'd31) begin
          busy_q <= 1'b0;
          done_o <= 1'b1;
        end
      end
    end
  end

  // restoring step, one quotient bit per cycle
  always_ff @(posedge clk_pixel) begin
    if (load) begin
      quo_q <= dividend_i;
      rem_q <= '0;
      div_q <= divisor_i;
    end else if (busy_q) begin
      quo_q <= {quo_q[30:0], fits};
      // remainder stays below the divisor, 21 bits hold it
      rem_q <= fits ? rem_sub[20:0] : rem_shift[20:0];
    end
  end

  assign quotient_o = quo_q;

endmodule

/* hw/centroid_tracker.sv */
module centroid_tracker (
  input  logic               clk_pixel,
  input  logic               recent_reset,
  input  keyer_pkg::hcount_t x_i,
  input  keyer_pkg::vcount_t y_i,
  input  logic               active_i,
  input  logic               key_i,
  input  logic               new_frame_i,
  output keyer_pkg::hcount_t centroid_x_o,
  output keyer_pkg::vcount_t centroid_y_o,
  output logic               centroid_valid_o
);

  // ==============================
  // per-frame accumulation
  // ==============================

  // 1280*720 pixels at x below 1280 stays under 2^31
  logic [31:0] sum_x_q;
  logic [31:0] sum_y_q;
  logic [20:0] count_q;
  logic        start_q;

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      sum_x_q <= '0;
      sum_y_q <= '0;
      count_q <= '0;
      start_q <= 1'b0;
    end else begin
      start_q <= 1'b0;
      if (new_frame_i) begin
        sum_x_q <= '0;
        sum_y_q <= '0;
        count_q <= '0;
        // empty frame, no division and the old centroid stays
        start_q <= (count_q != '0);
      end else if (active_i && !key_i) begin
        sum_x_q <= sum_x_q + 32'(x_i);
        sum_y_q <= sum_y_q + 32'(y_i);
        count_q <= count_q + 1'b1;
      end
    end
  end

  // totals held for the dividers while the next frame accumulates
  logic [31:0] lat_x_q;
  logic [31:0] lat_y_q;
  logic [20:0] lat_n_q;

  always_ff @(posedge clk_pixel) begin
    if (new_frame_i) begin
      lat_x_q <= sum_x_q;
      lat_y_q <= sum_y_q;
      lat_n_q <= count_q;
    end
  end

  // ==============================
  // division
  // ==============================

  logic [31:0] quo_x;
  logic [31:0] quo_y;
  logic        done_x;
  logic        done_y;

  seq_divider div_x (
    .clk_pixel(clk_pixel),
    .recent_reset(recent_reset),
    .start_i(start_q),
    .dividend_i(lat_x_q),
    .divisor_i(lat_n_q),
    .quotient_o(quo_x),
    .done_o(done_x)
  );

  seq_divider div_y (
    .clk_pixel(clk_pixel),
    .recent_reset(recent_reset),
    .start_i(start_q),
    .dividend_i(lat_y_q),
    .divisor_i(lat_n_q),
    .quotient_o(quo_y),
    .done_o(done_y)
  );

  // both start together and take the same time, so done is shared
  // mean lies within the raster, upper quotient bits are zero
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      centroid_x_o     <= '0;
      centroid_y_o     <= '0;
      centroid_valid_o <= 1'b0;
    end else begin
      centroid_valid_o <= done_x && done_y;
      if (done_x && done_y) begin
        centroid_x_o <= quo_x[10:0];
        centroid_y_o <= quo_y[9:0];
      end
    end
  end

endmodule

/* hw/pixel_mux.sv */
module pixel_mux (
  input  logic                  clk_pixel,
  input  logic                  recent_reset,
  input  keyer_pkg::disp_mode_t mode_i,
  input  keyer_pkg::hcount_t    x_i,
  input  keyer_pkg::vcount_t    y_i,
  input  logic                  active_i,
  input  keyer_pkg::rgb_t       rgb_i,
  input  keyer_pkg::chan_t      luma_i,
  input  logic                  key_i,
  input  keyer_pkg::hcount_t    centroid_x_i,
  input  keyer_pkg::vcount_t    centroid_y_i,
  output keyer_pkg::rgb_t       pixel_o
);

  logic            on_crosshair;
  keyer_pkg::rgb_t view;

  // full row and full column through the centroid
  assign on_crosshair = (x_i == centroid_x_i) || (y_i == centroid_y_i);

  always_comb begin
    case (mode_i)
      keyer_pkg::MODE_CAMERA: begin
        view = rgb_i;
      end
      // gray from Y on all three channels
      keyer_pkg::MODE_LUMA: begin
        view = '{red: luma_i, green: luma_i, blue: luma_i};
      end
      // player white, background black
      keyer_pkg::MODE_MASK: begin
        view = key_i ? 24'h000000 : 24'hFFFFFF;
      end
      keyer_pkg::MODE_CROSSHAIR: begin
        view = on_crosshair ? keyer_pkg::CROSSHAIR_COLOR : rgb_i;
      end
      default: begin
        view = rgb_i;
      end
    endcase
  end

  // blanking goes out black
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      pixel_o <= '0;
    end else begin
      pixel_o <= active_i ? view : '0;
    end
  end

endmodule

/* hw/chroma_keyer_top.sv */
module chroma_keyer_top #(
  parameter int H_ACTIVE = 1280,
  parameter int H_FRONT  = 110,
  parameter int H_SYNC   = 40,
  parameter int H_BACK   = 220,
  parameter int V_ACTIVE = 720,
  parameter int V_FRONT  = 5,
  parameter int V_SYNC   = 5,
  parameter int V_BACK   = 20
) (
  input  logic                  clk_pixel,
  input  logic                  recent_reset,
  input  keyer_pkg::pixel565_t  pixel_i,
  input  keyer_pkg::disp_mode_t mode_i,
  input  keyer_pkg::bound_t     cr_upper_i,
  input  keyer_pkg::bound_t     cb_upper_i,
  output keyer_pkg::hcount_t    hcount_o,
  output keyer_pkg::vcount_t    vcount_o,
  output keyer_pkg::chan_t      red_o,
  output keyer_pkg::chan_t      green_o,
  output keyer_pkg::chan_t      blue_o,
  output logic                  out_hsync_o,
  output logic                  out_vsync_o,
  output logic                  out_active_o,
  output keyer_pkg::hcount_t    centroid_x_o,
  output keyer_pkg::vcount_t    centroid_y_o,
  output logic                  centroid_valid_o
);

  // coordinate to registered mask
  localparam int MASK_DELAY = keyer_pkg::FETCH_LATENCY + keyer_pkg::KEY_LATENCY;

  // timing at the coordinate stage
  logic hsync;
  logic vsync;
  logic active;
  logic new_frame;

  // keying results
  keyer_pkg::rgb_t  key_rgb;
  keyer_pkg::chan_t key_luma;
  logic             key_mask;

  // coordinates and strobes in step with the mask
  keyer_pkg::hcount_t mask_hcount;
  keyer_pkg::vcount_t mask_vcount;
  logic               mask_active;
  logic               mask_new_frame;

  keyer_pkg::rgb_t out_pixel;

  // ==============================
  // raster and keying
  // ==============================

  video_timing #(
    .H_ACTIVE(H_ACTIVE),
    .H_FRONT(H_FRONT),
    .H_SYNC(H_SYNC),
    .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE),
    .V_FRONT(V_FRONT),
    .V_SYNC(V_SYNC),
    .V_BACK(V_BACK)
  ) timing (
    .clk_pixel(clk_pixel),
    .recent_reset(recent_reset),
    .hcount_o(hcount_o),
    .vcount_o(vcount_o),
    .hsync_o(hsync),
    .vsync_o(vsync),
    .active_o(active),
    .new_frame_o(new_frame)
  );

  // pixel_i arrives one cycle behind its coordinate
  chroma_key keyer (
    .clk_pixel(clk_pixel),
    .recent_reset(recent_reset),
    .pixel_i(pixel_i),
    .cr_upper_i(cr_upper_i),
    .cb_upper_i(cb_upper_i),
    .rgb_o(key_rgb),
    .luma_o(key_luma),
    .key_o(key_mask)
  );

  // ==============================
  // alignment
  // ==============================

  delay_line #(.payload_t(keyer_pkg::hcount_t), .DEPTH(MASK_DELAY)) hcount_delay (
    .clk_pixel(clk_pixel),
    .recent_reset(recent_reset),
    .data_i(hcount_o),
    .data_o(mask_hcount)
  );

  delay_line #(.payload_t(keyer_pkg::vcount_t), .DEPTH(MASK_DELAY)) vcount_delay (
    .clk_pixel(clk_pixel),
    .recent_reset(recent_reset),
    .data_i(vcount_o),
    .data_o(mask_vcount)
  );

  // new frame rides along with active so the tracker closes on the last pixel
  delay_line #(.payload_t(logic [1:0]), .DEPTH(MASK_DELAY)) flag_delay (
    .clk_pixel(clk_pixel),
    .recent_reset(recent_reset),
    .data_i({new_frame, active}),
    .data_o({mask_new_frame, mask_active})
  );

  // syncs and active straight to the output pins
  delay_line #(.payload_t(logic [2:0]), .DEPTH(keyer_pkg::OUT_LATENCY)) sync_delay (
    .clk_pixel(clk_pixel),
    .recent_reset(recent_reset),
    .data_i({hsync, vsync, active}),
    .data_o({out_hsync_o, out_vsync_o, out_active_o})
  );

  // ==============================
  // tracking and output
  // ==============================

  centroid_tracker tracker (
    .clk_pixel(clk_pixel),
    .recent_reset(recent_reset),
    .x_i(mask_hcount),
    .y_i(mask_vcount),
    .active_i(mask_active),
    .key_i(key_mask),
    .new_frame_i(mask_new_frame),
    .centroid_x_o(centroid_x_o),
    .centroid_y_o(centroid_y_o),
    .centroid_valid_o(centroid_valid_o)
  );

  pixel_mux mux (
    .clk_pixel(clk_pixel),
    .recent_reset(recent_reset),
    .mode_i(mode_i),
    .x_i(mask_hcount),
    .y_i(mask_vcount),
    .active_i(mask_active),
    .rgb_i(key_rgb),
    .luma_i(key_luma),
    .key_i(key_mask),
    .centroid_x_i(centroid_x_o),
    .centroid_y_i(centroid_y_o),
    .pixel_o(out_pixel)
  );

  assign red_o   = out_pixel.red;
  assign green_o = out_pixel.green;
  assign blue_o  = out_pixel.blue;

endmodule

/* test/chroma_keyer_asserts.sv */
module chroma_keyer_asserts (
  input logic clk_pixel,
  input logic recent_reset,
  input logic active_i,
  input logic out_active_i,
  input logic centroid_valid_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // valid is a single-cycle strobe
  valid_single: assert property (@(posedge clk_pixel) disable iff (recent_reset)
    centroid_valid_i |=> !centroid_valid_i)
    else $error("centroid_valid_o high on two consecutive cycles");

  // outputs cleared by the reset cycle before
  reset_quiet: assert property (@(posedge clk_pixel)
    recent_reset |=> !out_active_i && !centroid_valid_i)
    else $error("outputs active during reset");

  // active travels the whole pipeline
  active_latency: assert property (@(posedge clk_pixel) disable iff (recent_reset)
    $rose(active_i) |-> ##(keyer_pkg::OUT_LATENCY) $rose(out_active_i))
    else $error("out_active_o not aligned with active_o");

endmodule

bind chroma_keyer_top chroma_keyer_asserts asserts0 (
  .clk_pixel(clk_pixel),
  .recent_reset(recent_reset),
  .active_i(active),
  .out_active_i(out_active_o),
  .centroid_valid_i(centroid_valid_o)
);

/* test/tb_chroma_keyer.sv */
module tb_chroma_keyer;
  timeunit 1ns;
  timeprecision 1ps;

  // ==============================
  // raster and run length
  // ==============================

  localparam int H_ACT = 32;
  localparam int H_TOT = 48;
  localparam int V_ACT = 16;
  localparam int V_TOT = 24;
  localparam int NUM_FRAMES = 12;
  localparam longint WATCHDOG_NS = longint'(NUM_FRAMES) * H_TOT * V_TOT * 20 * 2;

  // key-green in RGB565, keyed once cr bound >= 3 and cb bound >= 4
  localparam keyer_pkg::pixel565_t GREEN = 16'h07E0;

  // crosshair drawn in full red
  localparam keyer_pkg::rgb_t FULL_RED = 24'hFF0000;

  // one output cycle worth of expected values
  typedef struct packed {
    keyer_pkg::rgb_t    pix;
    logic               hs;
    logic               vs;
    logic               act;
    logic               frame_end;
    logic               pulse;
    keyer_pkg::hcount_t cx;
    keyer_pkg::vcount_t cy;
  } expect_t;

  logic                  clk_pixel = 1'b0;
  logic                  recent_reset;
  keyer_pkg::pixel565_t  pixel_i;
  keyer_pkg::disp_mode_t mode_i;
  keyer_pkg::bound_t     cr_upper_i;
  keyer_pkg::bound_t     cb_upper_i;
  keyer_pkg::hcount_t    hcount_o;
  keyer_pkg::vcount_t    vcount_o;
  keyer_pkg::chan_t      red_o;
  keyer_pkg::chan_t      green_o;
  keyer_pkg::chan_t      blue_o;
  logic                  out_hsync_o;
  logic                  out_vsync_o;
  logic                  out_active_o;
  keyer_pkg::hcount_t    centroid_x_o;
  keyer_pkg::vcount_t    centroid_y_o;
  logic                  centroid_valid_o;

  // current scene, changed only at the end of a frame
  int                    frame_idx;
  int                    scene_kind;
  int                    rx0, rx1, ry0, ry1;
  keyer_pkg::pixel565_t  rect_color;
  keyer_pkg::disp_mode_t cur_mode;
  keyer_pkg::bound_t     cur_cr;
  keyer_pkg::bound_t     cur_cb;

  // model centroid and its running sums
  int                    sum_x, sum_y, count;
  keyer_pkg::hcount_t    model_cx;
  keyer_pkg::vcount_t    model_cy;

  expect_t               exp_q[$];
  int                    frames_checked;

  chroma_keyer_top #(
    .H_ACTIVE(H_ACT), .H_FRONT(4), .H_SYNC(4), .H_BACK(8),
    .V_ACTIVE(V_ACT), .V_FRONT(2), .V_SYNC(2), .V_BACK(4)
  ) dut0 (
    .clk_pixel(clk_pixel),
    .recent_reset(recent_reset),
    .pixel_i(pixel_i),
    .mode_i(mode_i),
    .cr_upper_i(cr_upper_i),
    .cb_upper_i(cb_upper_i),
    .hcount_o(hcount_o),
    .vcount_o(vcount_o),
    .red_o(red_o),
    .green_o(green_o),
    .blue_o(blue_o),
    .out_hsync_o(out_hsync_o),
    .out_vsync_o(out_vsync_o),
    .out_active_o(out_active_o),
    .centroid_x_o(centroid_x_o),
    .centroid_y_o(centroid_y_o),
    .centroid_valid_o(centroid_valid_o)
  );

  always #10 clk_pixel = ~clk_pixel;

  // ==============================
  // reference model
  // ==============================

  function automatic keyer_pkg::rgb_t expand565(keyer_pkg::pixel565_t p);
    keyer_pkg::rgb_t c;
    c.red   = {p[15:11], 3'b000};
    c.green = {p[10:5], 2'b00};
    c.blue  = {p[4:0], 3'b000};
    return c;
  endfunction

  function automatic keyer_pkg::chan_t luma_of(keyer_pkg::rgb_t c);
    int s;
    s = 66 * int'(c.red) + 129 * int'(c.green) + 25 * int'(c.blue);
    return keyer_pkg::chan_t'((s >>> 8) + 16);
  endfunction

  // 1 for background, both chroma values at or under their bounds
  function automatic logic key_of(keyer_pkg::rgb_t c, keyer_pkg::bound_t cr_b,
                                  keyer_pkg::bound_t cb_b);
    int cr_s;
    int cb_s;
    keyer_pkg::chan_t cr;
    keyer_pkg::chan_t cb;
    cr_s = 112 * int'(c.red) - 94 * int'(c.green) - 18 * int'(c.blue);
    cb_s = -38 * int'(c.red) - 74 * int'(c.green) + 112 * int'(c.blue);
    cr = keyer_pkg::chan_t'((cr_s >>> 8) + 128);
    cb = keyer_pkg::chan_t'((cb_s >>> 8) + 128);
    return (int'(cr) <= int'(cr_b) * 16) && (int'(cb) <= int'(cb_b) * 16);
  endfunction

  function automatic keyer_pkg::rgb_t ref_pixel(keyer_pkg::pixel565_t p, int x, int y);
    keyer_pkg::rgb_t c;
    keyer_pkg::chan_t l;
    c = expand565(p);
    l = luma_of(c);
    if (x >= H_ACT || y >= V_ACT) begin
      return '0;
    end
    case (cur_mode)
      keyer_pkg::MODE_LUMA: return {l, l, l};
      keyer_pkg::MODE_MASK: return key_of(c, cur_cr, cur_cb) ? 24'h000000 : 24'hFFFFFF;
      keyer_pkg::MODE_CROSSHAIR: begin
        if (x == int'(model_cx) || y == int'(model_cy)) begin
          return FULL_RED;
        end
        return c;
      end
      default: return c;
    endcase
  endfunction

  // ==============================
  // scenes
  // ==============================

  // kind 0 green with a rectangle, 1 noise, 2 green only
  task automatic setup_frame(int f);
    scene_kind = (f == 5) ? 2 : ((f % 3 == 2) ? 1 : 0);
    rx0 = $urandom % 24;
    rx1 = rx0 + 2 + $urandom % 8;
    ry0 = $urandom % 12;
    ry1 = ry0 + 2 + $urandom % 4;
    // red forced high keeps the rectangle off green
    rect_color = keyer_pkg::pixel565_t'($urandom) | 16'hF800;
    cur_mode = keyer_pkg::disp_mode_t'(f % 4);
    cur_cr = keyer_pkg::bound_t'(3 + $urandom % 13);
    cur_cb = keyer_pkg::bound_t'(4 + $urandom % 12);
    mode_i <= cur_mode;
    cr_upper_i <= cur_cr;
    cb_upper_i <= cur_cb;
  endtask

  function automatic keyer_pkg::pixel565_t scene_pixel(int x, int y);
    if (scene_kind == 1) begin
      return keyer_pkg::pixel565_t'($urandom);
    end
    if (scene_kind == 0 && x >= rx0 && x < rx1 && y >= ry0 && y < ry1) begin
      return rect_color;
    end
    return GREEN;
  endfunction

  // ==============================
  // compare tasks
  // ==============================

  task automatic fail_now();
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_rgb(string name, keyer_pkg::rgb_t exp, keyer_pkg::rgb_t act);
    if (exp !== act) begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      fail_now();
    end
  endtask

  task automatic check_hcount(string name, keyer_pkg::hcount_t exp, keyer_pkg::hcount_t act);
    if (exp !== act) begin
      $display("ERROR %s expected %0d actual %0d", name, exp, act);
      fail_now();
    end
  endtask

  task automatic check_vcount(string name, keyer_pkg::vcount_t exp, keyer_pkg::vcount_t act);
    if (exp !== act) begin
      $display("ERROR %s expected %0d actual %0d", name, exp, act);
      fail_now();
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("ERROR %s expected %b actual %b", name, exp, act);
      fail_now();
    end
  endtask

  // ==============================
  // stimulus
  // ==============================

  always @(posedge clk_pixel) begin
    int h;
    int v;
    keyer_pkg::pixel565_t p;
    expect_t e;
    h = int'(hcount_o);
    v = int'(vcount_o);
    p = scene_pixel(h, v);
    pixel_i <= p;
    if (!recent_reset) begin
      e = '0;
      e.pix = ref_pixel(p, h, v);
      e.hs  = (h >= 36 && h < 40);
      e.vs  = (v >= 18 && v < 20);
      e.act = (h < H_ACT && v < V_ACT);
      if (e.act && !key_of(expand565(p), cur_cr, cur_cb)) begin
        sum_x += h;
        sum_y += v;
        count++;
      end
      if (h == H_TOT - 1 && v == V_TOT - 1) begin
        // frame closed, empty frames hold the old centroid
        if (count > 0) begin
          model_cx = keyer_pkg::hcount_t'(sum_x / count);
          model_cy = keyer_pkg::vcount_t'(sum_y / count);
        end
        e.frame_end = 1'b1;
        e.pulse = (count > 0);
        e.cx = model_cx;
        e.cy = model_cy;
        sum_x = 0;
        sum_y = 0;
        count = 0;
        frame_idx++;
        setup_frame(frame_idx);
      end
      exp_q.push_back(e);
    end
  end

  // ==============================
  // compare process
  // ==============================

  always @(negedge clk_pixel) begin
    expect_t e;
    int pulses;
    keyer_pkg::hcount_t exp_h;
    keyer_pkg::vcount_t exp_v;
    if (recent_reset) begin
      exp_h = '0;
      exp_v = '0;
      pulses = 0;
      check_bit("reset out_active", 1'b0, out_active_o);
      check_bit("reset centroid_valid", 1'b0, centroid_valid_o);
      check_hcount("reset centroid x", '0, centroid_x_o);
      check_vcount("reset centroid y", '0, centroid_y_o);
    end else begin
      check_hcount("raster hcount", exp_h, hcount_o);
      check_vcount("raster vcount", exp_v, vcount_o);
      if (int'(exp_h) == H_TOT - 1) begin
        exp_h = '0;
        exp_v = (int'(exp_v) == V_TOT - 1) ? '0 : exp_v + 1'b1;
      end else begin
        exp_h = exp_h + 1'b1;
      end
      if (centroid_valid_o) begin
        pulses++;
      end
      // pipeline still filling from reset
      e = '0;
      if (exp_q.size() == keyer_pkg::OUT_LATENCY) begin
        e = exp_q.pop_front();
      end
      check_rgb($sformatf("frame %0d pixel", frames_checked), e.pix,
                {red_o, green_o, blue_o});
      check_bit("out_active", e.act, out_active_o);
      check_bit("out_hsync", e.hs, out_hsync_o);
      check_bit("out_vsync", e.vs, out_vsync_o);
      if (e.frame_end) begin
        if (pulses > 1) begin
          $display("centroid valid pulsed %0d times in one frame", pulses);
          fail_now();
        end
        check_bit($sformatf("frame %0d centroid pulse", frames_checked), e.pulse, pulses != 0);
        check_hcount($sformatf("frame %0d centroid x", frames_checked), e.cx, centroid_x_o);
        check_vcount($sformatf("frame %0d centroid y", frames_checked), e.cy, centroid_y_o);
        pulses = 0;
        frames_checked++;
      end
    end
  end

  // ==============================
  // run control
  // ==============================

  initial begin
    void'($urandom(46639));
    frame_idx = 0;
    frames_checked = 0;
    sum_x = 0;
    sum_y = 0;
    count = 0;
    model_cx = '0;
    model_cy = '0;
    pixel_i = '0;
    recent_reset = 1'b1;
    setup_frame(0);
    repeat (16) @(posedge clk_pixel);
    recent_reset <= 1'b0;
    wait (frames_checked == NUM_FRAMES);
    $display("All checks passed");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout, frames did not complete in time");
    $display("Checks failed");
    $fatal(1);
  end

endmodule

/* chroma_keyer.f */
hw/keyer_pkg.sv
hw/delay_line.sv
hw/video_timing.sv
hw/chroma_key.sv
hw/seq_divider.sv
hw/centroid_tracker.sv
hw/pixel_mux.sv
hw/chroma_keyer_top.sv
test/chroma_keyer_asserts.sv
test/tb_chroma_keyer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the chroma keyer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_chroma_keyer \
  -f chroma_keyer.f -o sim_chroma_keyer > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_chroma_keyer > sim.log 2>&1

grep -q "All checks passed" sim.log && ! grep -q "Checks failed" sim.log \
  && echo "PASS" \
  || { echo "FAIL, see sim.log"; exit 1; }
